// ==== bench/frontend_props.sv ====
// bound checks on the front-end top level
// register fields, stall stability, redirect priority, flush and idle lock
module frontend_props (
  input logic                                                      clk,
  input logic                                                      rst_n,
  input logic                                                      fetch_ready_o,
  input frontend_pkg::dec_inst_t [frontend_pkg::DECODE_WIDTH-1:0] dec_o,
  input logic [frontend_pkg::DECODE_WIDTH-1:0]                     dec_valid_o,
  input logic                                                      dec_ready_i,
  input frontend_pkg::commit_t                                     commit_i,
  input frontend_pkg::csr_vec_t                                    csr_i,
  input logic                                                      has_int_i,
  input logic                                                      redirect_valid_o,
  input logic [frontend_pkg::XLEN-1:0]                             redirect_target_o,
  input logic                                                      fetch_enable_o
);
  import frontend_pkg::*;

  int unsigned     err_cnt;
  logic            cause;
  logic [XLEN-1:0] exp_target;

  initial err_cnt = 0;

  // type codes ride in instr[31:26]: src0, src1, dest
  function automatic logic [4:0] src_reg(logic [1:0] code, logic [31:0] w);
    return (code == 2'd1) ? w[4:0] : (code == 2'd2) ? w[9:5] : (code == 2'd3) ? w[14:10] : 5'd0;
  endfunction

  function automatic logic [4:0] dest_reg(logic [1:0] code, logic [31:0] w);
    return (code == 2'd1) ? w[4:0] : (code == 2'd2) ? (w[9:5] | w[4:0])
         : (code == 2'd3) ? 5'd1 : 5'd0;
  endfunction

  assign cause = commit_i.valid & (commit_i.excp | commit_i.br_redirect | commit_i.ertn
               | commit_i.ibar | commit_i.priv | commit_i.icacop | commit_i.idle);

  // refill, exception, branch, return, then refetch
  assign exp_target = (commit_i.excp && commit_i.ecode == ECODE_TLBR) ? csr_i.tlbrentry
                    : commit_i.excp        ? csr_i.eentry
                    : commit_i.br_redirect ? commit_i.br_target
                    : commit_i.ertn        ? csr_i.era
                    : commit_i.pc + XLEN'(INST_BYTES);

  // ========================================
  // decode side
  // ========================================
  for (genvar k = 0; k < DECODE_WIDTH; k++) begin : g_lane
    a_fields: assert property (@(posedge clk) disable iff (!rst_n)
      dec_valid_o[k] |-> dec_o[k].src0 == src_reg(dec_o[k].instr[31:30], dec_o[k].instr)
                      && dec_o[k].src1 == src_reg(dec_o[k].instr[29:28], dec_o[k].instr)
                      && dec_o[k].dest == dest_reg(dec_o[k].instr[27:26], dec_o[k].instr))
      else begin
        err_cnt++;
        $error("Error: time %0t signal dec_o[%0d] fields got %h %h %h expected %h %h %h",
               $time, k, dec_o[k].src0, dec_o[k].src1, dec_o[k].dest,
               src_reg(dec_o[k].instr[31:30], dec_o[k].instr),
               src_reg(dec_o[k].instr[29:28], dec_o[k].instr),
               dest_reg(dec_o[k].instr[27:26], dec_o[k].instr));
      end
  end

  a_lane_order: assert property (@(posedge clk) disable iff (!rst_n)
    dec_valid_o[1] |-> dec_valid_o[0])
    else begin
      err_cnt++;
      $error("dec_valid_o is %b, lane 1 without lane 0", dec_valid_o);
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (|dec_valid_o) && !dec_ready_i && !redirect_valid_o |=> $stable(dec_o) && $stable(dec_valid_o))
    else begin
      err_cnt++;
      $error("dec_o or dec_valid_o changed under stall, dec_valid_o now %b", dec_valid_o);
    end

  // ========================================
  // redirect and flush
  // ========================================
  a_target: assert property (@(posedge clk) disable iff (!rst_n)
    cause && !redirect_valid_o |=> redirect_valid_o && redirect_target_o == $past(exp_target))
    else begin
      err_cnt++;
      $error("Error: time %0t signal redirect_target_o got %h expected %h, valid %b",
             $time, redirect_target_o, $past(exp_target), redirect_valid_o);
    end

  a_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_valid_o |=> !redirect_valid_o)
    else begin
      err_cnt++;
      $error("redirect_valid_o high for more than one cycle");
    end

  a_flush: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_valid_o |-> !fetch_ready_o ##1 dec_valid_o == '0)
    else begin
      err_cnt++;
      $error("flush not seen, fetch_ready_o %b dec_valid_o %b", fetch_ready_o, dec_valid_o);
    end

  // ========================================
  // idle lock
  // ========================================
  a_idle_lock: assert property (@(posedge clk) disable iff (!rst_n)
    commit_i.valid && commit_i.idle && !has_int_i |=> !fetch_enable_o)
    else begin
      err_cnt++;
      $error("Error: time %0t signal fetch_enable_o got %b expected 0 after idle commit",
             $time, fetch_enable_o);
    end

  a_idle_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !fetch_enable_o && !has_int_i |=> !fetch_enable_o)
    else begin
      err_cnt++;
      $error("Error: time %0t signal fetch_enable_o got %b expected 0 with no interrupt",
             $time, fetch_enable_o);
    end

  a_idle_wake: assert property (@(posedge clk) disable iff (!rst_n)
    has_int_i |=> fetch_enable_o)
    else begin
      err_cnt++;
      $error("Error: time %0t signal fetch_enable_o got %b expected 1 after interrupt",
             $time, fetch_enable_o);
    end

endmodule

bind frontend_top frontend_props i_props (
  .clk               (clk),
  .rst_n             (rst_n),
  .fetch_ready_o     (fetch_ready_o),
  .dec_o             (dec_o),
  .dec_valid_o       (dec_valid_o),
  .dec_ready_i       (dec_ready_i),
  .commit_i          (commit_i),
  .csr_i             (csr_i),
  .has_int_i         (has_int_i),
  .redirect_valid_o  (redirect_valid_o),
  .redirect_target_o (redirect_target_o),
  .fetch_enable_o    (fetch_enable_o)
);

// ==== bench/frontend_tb.sv ====
// testbench for the front-end glue top level
// random fetch and decode traffic, redirects and idle lock, with an order scoreboard
module frontend_tb;
  import frontend_pkg::*;

  logic                         clk;
  logic                         rst_n;
  fetch_pkt_t                   fetch_pkt_i;
  logic                         fetch_valid_i;
  logic                         fetch_ready_o;
  dec_inst_t [DECODE_WIDTH-1:0] dec_o;
  logic [DECODE_WIDTH-1:0]      dec_valid_o;
  logic                         dec_ready_i;
  commit_t                      commit_i;
  csr_vec_t                     csr_i;
  logic                         has_int_i;
  logic                         redirect_valid_o;
  logic [XLEN-1:0]              redirect_target_o;
  logic                         fetch_enable_o;

  integer          seed;
  // expected {pc, instr} in program order
  logic [63:0]     exp_q[$];
  logic            new_pkt;
  logic [10:0]     seq;
  logic [XLEN-1:0] fetch_pc;
  int              n;

  frontend_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // handshakes are sampled a quarter period before the rising edge
  task automatic tick();
    logic [63:0] want;
    #10;
    new_pkt = 1'b0;
    if (dec_ready_i) begin
      for (int k = 0; k < DECODE_WIDTH; k++) begin
        if (dec_valid_o[k]) begin
          if (exp_q.size() == 0) begin
            fail_run($sformatf("decode lane %0d delivered an instruction never fetched", k));
          end
          want = exp_q.pop_front();
          if (dec_o[k].instr !== want[31:0]) begin
            fail_run($sformatf("Error: time %0t signal dec_o[%0d].instr got %08h expected %08h",
                               $time, k, dec_o[k].instr, want[31:0]));
          end
          if (dec_o[k].pc !== want[63:32]) begin
            fail_run($sformatf("Error: time %0t signal dec_o[%0d].pc got %08h expected %08h",
                               $time, k, dec_o[k].pc, want[63:32]));
          end
        end
      end
    end
    if (fetch_valid_i && fetch_ready_o) begin
      new_pkt = 1'b1;
      for (int s = 0; s < FETCH_WIDTH; s++) begin
        if (fetch_pkt_i.slot_valid[s]) begin
          exp_q.push_back({fetch_pkt_i.slot[s].pc, fetch_pkt_i.slot[s].instr});
        end
      end
    end
    // everything fetched so far is flushed
    if (redirect_valid_o) begin
      exp_q.delete();
      new_pkt = 1'b1;
    end
    if (i_dut.i_props.err_cnt != 0) begin
      fail_run("a bound assertion on the DUT failed");
    end
    @(negedge clk);
  endtask

  task automatic drive_fetch(input logic en);
    logic [31:0] r;
    if (!en || !fetch_enable_o) begin
      fetch_valid_i = 1'b0;
    end else if (new_pkt || !fetch_valid_i) begin
      fetch_valid_i          = 1'b1;
      fetch_pkt_i.slot_valid = FETCH_WIDTH'($random(seed));
      for (int s = 0; s < FETCH_WIDTH; s++) begin
        r = $random(seed);
        // instr[31:26] repeats the type codes, instr[25:15] keeps words unique
        fetch_pkt_i.slot[s].pc        = fetch_pc;
        fetch_pkt_i.slot[s].instr     = {r[5:0], seq, r[14:0]};
        fetch_pkt_i.slot[s].src0_type = src_type_e'(r[5:4]);
        fetch_pkt_i.slot[s].src1_type = src_type_e'(r[3:2]);
        fetch_pkt_i.slot[s].dest_type = dest_type_e'(r[1:0]);
        fetch_pc = fetch_pc + XLEN'(INST_BYTES);
        seq++;
      end
    end
  endtask

  // cause bits: excp, br_redirect, ertn, ibar, priv, icacop, idle
  task automatic commit_once(input logic [6:0] cause, input logic [5:0] ecode);
    commit_i       = '0;
    commit_i.valid = 1'b1;
    {commit_i.excp, commit_i.br_redirect, commit_i.ertn, commit_i.ibar,
     commit_i.priv, commit_i.icacop, commit_i.idle} = cause;
    commit_i.ecode     = ecode;
    commit_i.pc        = $random(seed);
    commit_i.br_target = $random(seed);
    drive_fetch(1'b1);
    tick();
    commit_i = '0;
  endtask

  task automatic random_cycle();
    logic [31:0] r;
    r           = $random(seed);
    dec_ready_i = r[1:0] != 2'b00;
    has_int_i   = r[7:4] == 4'h0;
    if (r[12:8] == 5'h0) begin
      commit_once(r[19:13], r[20] ? ECODE_TLBR : r[26:21]);
    end else begin
      drive_fetch(1'b1);
      tick();
    end
  endtask

  task automatic redirect_case(input logic [6:0] cause, input logic [5:0] ecode);
    commit_once(cause, ecode);
    repeat (3) begin
      drive_fetch(1'b1);
      tick();
    end
  endtask

  initial begin
    seed          = 32'hee14_9d52;
    rst_n         = 1'b0;
    fetch_pkt_i   = '0;
    fetch_valid_i = 1'b0;
    dec_ready_i   = 1'b0;
    commit_i      = '0;
    csr_i         = '0;
    has_int_i     = 1'b0;
    new_pkt       = 1'b0;
    seq           = '0;
    fetch_pc      = 32'h1c00_0000;
    repeat (16) @(negedge clk);
    rst_n           = 1'b1;
    csr_i.eentry    = $random(seed);
    csr_i.tlbrentry = $random(seed);
    csr_i.era       = $random(seed);

    // mixed traffic
    repeat (400) random_cycle();

    // long decode stall until the queue pushes back
    has_int_i   = 1'b1;
    dec_ready_i = 1'b0;
    n = 0;
    while (fetch_ready_o && n < 60) begin
      drive_fetch(1'b1);
      tick();
      has_int_i = 1'b0;
      n++;
    end
    if (fetch_ready_o) begin
      fail_run("fetch_ready_o stayed high through a long decode stall");
    end
    repeat (4) begin
      drive_fetch(1'b1);
      tick();
    end

    // ========================================
    // redirect priority with stacked causes
    // ========================================
    dec_ready_i = 1'b1;
    redirect_case(7'b1111110, ECODE_TLBR);
    redirect_case(7'b1111110, 6'h01);
    redirect_case(7'b0111110, 6'h00);
    redirect_case(7'b0011110, 6'h00);
    redirect_case(7'b0000100, 6'h00);
    redirect_case(7'b0000010, 6'h00);

    // idle lock, released by an interrupt
    redirect_case(7'b0000001, 6'h00);
    repeat (4) begin
      drive_fetch(1'b1);
      tick();
    end
    has_int_i = 1'b1;
    n = 0;
    while (!fetch_enable_o && n < 10) begin
      drive_fetch(1'b1);
      tick();
      n++;
    end
    if (!fetch_enable_o) begin
      fail_run("fetch_enable_o did not return after the interrupt");
    end
    has_int_i = 1'b0;

    // drain
    n = 0;
    while ((exp_q.size() != 0 || dec_valid_o != '0) && n < 60) begin
      drive_fetch(1'b0);
      tick();
      n++;
    end
    if (exp_q.size() != 0) begin
      fail_run("decode never delivered all fetched instructions");
    end

    if (i_dut.i_props.err_cnt == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      fail_run("a bound assertion on the DUT failed");
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module frontend_tb -Mdir obj_dir -f sim.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

# let assertion errors reach the testbench instead of stopping at the first
./obj_dir/Vfrontend_tb +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit $status
fi

exit 0

// ==== sim.f ====
source/frontend_pkg.sv
source/fetch_compactor.sv
source/inst_queue.sv
source/reg_field_decoder.sv
source/commit_redirect.sv
source/frontend_top.sv
bench/frontend_props.sv
bench/frontend_tb.sv

// ==== source/commit_redirect.sv ====
// commit-side redirect
// flush cause classification, target select by priority and idle lock
module commit_redirect (
  input  logic                          clk,
  input  logic                          rst_n,
  input  frontend_pkg::commit_t         commit_i,
  input  frontend_pkg::csr_vec_t        csr_i,
  input  logic                          has_int_i,
  output logic                          redirect_valid_o,
  output logic [frontend_pkg::XLEN-1:0] redirect_target_o,
  output logic                          flush_o,
  output logic                          fetch_enable_o
);
  import frontend_pkg::*;

  logic            excp_flush;
  logic            tlbr_flush;
  logic            br_flush;
  logic            ertn_flush;
  logic            idle_flush;
  logic            refetch_flush;
  logic            any_flush;
  logic [XLEN-1:0] target;
  logic            redirect_q;
  logic [XLEN-1:0] target_q;
  logic            idle_lock_q;

  // ========================================
  // cause classification
  // ========================================
  always_comb begin
    excp_flush    = commit_i.valid & commit_i.excp;
    // refill also raises excp but has its own entry
    tlbr_flush    = excp_flush & (commit_i.ecode == ECODE_TLBR);
    br_flush      = commit_i.valid & commit_i.br_redirect;
    ertn_flush    = commit_i.valid & commit_i.ertn;
    idle_flush    = commit_i.valid & commit_i.idle;
    refetch_flush = (commit_i.valid & (commit_i.ibar | commit_i.priv | commit_i.icacop))
                  | idle_flush;
    any_flush     = excp_flush | br_flush | ertn_flush | refetch_flush;
  end

  always_comb begin
    if (tlbr_flush) begin
      target = csr_i.tlbrentry;
    end else if (excp_flush) begin
      target = csr_i.eentry;
    end else if (br_flush) begin
      target = commit_i.br_target;
    end else if (ertn_flush) begin
      target = csr_i.era;
    end else begin
      // refetch resumes after the committing instruction
      target = commit_i.pc + XLEN'(INST_BYTES);
    end
  end

  // one-cycle pulse; a commit seen during the flush cycle is already stale
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      redirect_q <= 1'b0;
    end else begin
      redirect_q <= any_flush & ~redirect_q;
    end
  end

  always_ff @(posedge clk) begin
    if (any_flush && !redirect_q) begin
      target_q <= target;
    end
  end

  // ========================================
  // idle lock
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_lock_q <= 1'b0;
    end else if (idle_flush && !has_int_i) begin
      idle_lock_q <= 1'b1;
    end else if (has_int_i) begin
      idle_lock_q <= 1'b0;
    end
  end

  assign redirect_valid_o  = redirect_q;
  assign redirect_target_o = target_q;
  assign flush_o           = redirect_q;
  assign fetch_enable_o    = ~idle_lock_q;

endmodule

// ==== source/fetch_compactor.sv ====
// fetch packet register and slot compaction
// squeezes invalid slots out and writes the rest onto the low queue ports
module fetch_compactor (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  flush_i,
  input  frontend_pkg::fetch_pkt_t                              pkt_i,
  input  logic                                                  pkt_valid_i,
  output logic                                                  pkt_ready_o,
  input  logic [frontend_pkg::IQ_CNT_W-1:0]                     iq_free_i,
  output logic [frontend_pkg::FETCH_WIDTH-1:0]                  wr_valid_o,
  output frontend_pkg::slot_t [frontend_pkg::FETCH_WIDTH-1:0]  wr_data_o
);
  import frontend_pkg::*;

  fetch_pkt_t pkt_q;
  logic       full_q;
  logic       room;
  logic       drain;

  // a whole packet must fit, whatever its mask
  assign room        = iq_free_i >= IQ_CNT_W'(FETCH_WIDTH);
  assign drain       = full_q & room & ~flush_i;
  assign pkt_ready_o = (~full_q | drain) & room;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (flush_i) begin
      full_q <= 1'b0;
    end else if (pkt_valid_i && pkt_ready_o) begin
      full_q <= 1'b1;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pkt_valid_i && pkt_ready_o) begin
      pkt_q <= pkt_i;
    end
  end

  // valid slots go to ports 0.. in slot order
  always_comb begin
    int unsigned idx;
    idx        = 0;
    wr_valid_o = '0;
    wr_data_o  = '0;
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      if (drain && pkt_q.slot_valid[s]) begin
        wr_valid_o[idx] = 1'b1;
        wr_data_o[idx]  = pkt_q.slot[s];
        idx++;
      end
    end
  end

endmodule

// ==== source/frontend_pkg.sv ====
// front-end glue definitions
// widths, operand type codes and the structs passed between the blocks
package frontend_pkg;

  // ========================================
  // widths and depths
  // ========================================
  localparam int FETCH_WIDTH  = 2;
  localparam int DECODE_WIDTH = 2;
  localparam int IQ_DEPTH     = 8;
  localparam int IQ_PTR_W     = $clog2(IQ_DEPTH);
  localparam int IQ_CNT_W     = $clog2(IQ_DEPTH + 1);
  localparam int XLEN         = 32;
  localparam int AREG_W       = 5;
  localparam int INST_BYTES   = 4;

  // tlb refill exception code
  localparam logic [5:0] ECODE_TLBR = 6'h3f;

  // ========================================
  // pre-decoded operand types
  // ========================================
  typedef enum logic [1:0] {
    SRC_R0 = 2'd0,
    SRC_RD = 2'd1,
    SRC_RJ = 2'd2,
    SRC_RK = 2'd3
  } src_type_e;

  // jd is the rd/rj merge used by jirl-style forms
  typedef enum logic [1:0] {
    DEST_R0 = 2'd0,
    DEST_RD = 2'd1,
    DEST_JD = 2'd2,
    DEST_RA = 2'd3
  } dest_type_e;

  // ========================================
  // payload structs
  // ========================================
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    src_type_e       src0_type;
    src_type_e       src1_type;
    dest_type_e      dest_type;
  } slot_t;

  typedef struct packed {
    logic [FETCH_WIDTH-1:0] slot_valid;
    slot_t [FETCH_WIDTH-1:0] slot;
  } fetch_pkt_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   instr;
    logic [AREG_W-1:0] src0;
    logic [AREG_W-1:0] src1;
    logic [AREG_W-1:0] dest;
  } dec_inst_t;

  // oldest instruction at commit
  typedef struct packed {
    logic            valid;
    logic            excp;
    logic [5:0]      ecode;
    logic            br_redirect;
    logic            ertn;
    logic            ibar;
    logic            priv;
    logic            icacop;
    logic            idle;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] br_target;
  } commit_t;

  typedef struct packed {
    logic [XLEN-1:0] eentry;
    logic [XLEN-1:0] tlbrentry;
    logic [XLEN-1:0] era;
  } csr_vec_t;

endpackage

// ==== source/frontend_top.sv ====
// front-end glue top level
// decode stage (compaction, queue, field decode) and commit redirect
module frontend_top (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  frontend_pkg::fetch_pkt_t                                  fetch_pkt_i,
  input  logic                                                      fetch_valid_i,
  output logic                                                      fetch_ready_o,
  output frontend_pkg::dec_inst_t [frontend_pkg::DECODE_WIDTH-1:0] dec_o,
  output logic [frontend_pkg::DECODE_WIDTH-1:0]                     dec_valid_o,
  input  logic                                                      dec_ready_i,
  input  frontend_pkg::commit_t                                     commit_i,
  input  frontend_pkg::csr_vec_t                                    csr_i,
  input  logic                                                      has_int_i,
  output logic                                                      redirect_valid_o,
  output logic [frontend_pkg::XLEN-1:0]                             redirect_target_o,
  output logic                                                      fetch_enable_o
);
  import frontend_pkg::*;

  logic                             flush;
  logic                             cmp_ready;
  logic [FETCH_WIDTH-1:0]           iq_wr_valid;
  slot_t [FETCH_WIDTH-1:0]          iq_wr_data;
  logic [IQ_CNT_W-1:0]              iq_free;
  slot_t [DECODE_WIDTH-1:0]         iq_rd_data;

  // no packet is taken during the redirect cycle
  assign fetch_ready_o = cmp_ready & ~flush;

  // ========================================
  // decode stage
  // ========================================
  fetch_compactor u_fetch_compactor (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush),
    .pkt_i       (fetch_pkt_i),
    .pkt_valid_i (fetch_valid_i),
    .pkt_ready_o (cmp_ready),
    .iq_free_i   (iq_free),
    .wr_valid_o  (iq_wr_valid),
    .wr_data_o   (iq_wr_data)
  );

  inst_queue u_inst_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush),
    .wr_valid_i (iq_wr_valid),
    .wr_data_i  (iq_wr_data),
    .free_o     (iq_free),
    .rd_valid_o (dec_valid_o),
    .rd_data_o  (iq_rd_data),
    .rd_ready_i (dec_ready_i)
  );

  reg_field_decoder u_reg_field_decoder (
    .slot_i (iq_rd_data),
    .dec_o  (dec_o)
  );

  // ========================================
  // result stage
  // ========================================
  commit_redirect u_commit_redirect (
    .clk               (clk),
    .rst_n             (rst_n),
    .commit_i          (commit_i),
    .csr_i             (csr_i),
    .has_int_i         (has_int_i),
    .redirect_valid_o  (redirect_valid_o),
    .redirect_target_o (redirect_target_o),
    .flush_o           (flush),
    .fetch_enable_o    (fetch_enable_o)
  );

endmodule

// ==== source/inst_queue.sv ====
// instruction queue, two writes and two reads per cycle
// circular buffer with flush; the head window holds steady under stall
module inst_queue (
  input  logic                                                  clk,
  input  logic                                                  rst_n,
  input  logic                                                  flush_i,
  input  logic [frontend_pkg::FETCH_WIDTH-1:0]                  wr_valid_i,
  input  frontend_pkg::slot_t [frontend_pkg::FETCH_WIDTH-1:0]  wr_data_i,
  output logic [frontend_pkg::IQ_CNT_W-1:0]                     free_o,
  output logic [frontend_pkg::DECODE_WIDTH-1:0]                 rd_valid_o,
  output frontend_pkg::slot_t [frontend_pkg::DECODE_WIDTH-1:0] rd_data_o,
  input  logic                                                  rd_ready_i
);
  import frontend_pkg::*;

  slot_t                                  mem [IQ_DEPTH];
  logic [IQ_PTR_W-1:0]                    head_q;
  logic [IQ_PTR_W-1:0]                    tail_q;
  logic [IQ_CNT_W-1:0]                    count_q;
  logic [IQ_CNT_W-1:0]                    n_wr;
  logic [IQ_CNT_W-1:0]                    n_rd;
  logic [FETCH_WIDTH-1:0][IQ_PTR_W-1:0]   wr_ptr;
  logic [DECODE_WIDTH-1:0]                avail;
  logic                                   hold_q;
  logic [DECODE_WIDTH-1:0]                hold_mask_q;

  // write slot offsets from the tail
  always_comb begin
    n_wr = '0;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      wr_ptr[k] = tail_q + IQ_PTR_W'(n_wr);
      if (wr_valid_i[k]) begin
        n_wr = n_wr + 1'b1;
      end
    end
  end

  always_comb begin
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      avail[k] = count_q > IQ_CNT_W'(k);
    end
  end

  // a stalled window keeps its mask so lane 1 cannot appear mid-stall
  assign rd_valid_o = hold_q ? hold_mask_q : avail;

  always_comb begin
    logic [IQ_PTR_W-1:0] rd_ptr;
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      rd_ptr       = head_q + IQ_PTR_W'(k);
      rd_data_o[k] = rd_valid_o[k] ? mem[rd_ptr] : '0;
    end
  end

  always_comb begin
    n_rd = '0;
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      if (rd_ready_i && rd_valid_o[k]) begin
        n_rd = n_rd + 1'b1;
      end
    end
  end

  assign free_o = IQ_CNT_W'(IQ_DEPTH) - count_q;

  // ========================================
  // pointers and count
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q      <= '0;
      tail_q      <= '0;
      count_q     <= '0;
      hold_q      <= 1'b0;
      hold_mask_q <= '0;
    end else if (flush_i) begin
      head_q      <= '0;
      tail_q      <= '0;
      count_q     <= '0;
      hold_q      <= 1'b0;
      hold_mask_q <= '0;
    end else begin
      head_q      <= head_q + IQ_PTR_W'(n_rd);
      tail_q      <= tail_q + IQ_PTR_W'(n_wr);
      count_q     <= count_q + n_wr - n_rd;
      hold_q      <= (|rd_valid_o) & ~rd_ready_i;
      hold_mask_q <= rd_valid_o;
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      if (wr_valid_i[k]) begin
        mem[wr_ptr[k]] <= wr_data_i[k];
      end
    end
  end

endmodule

// ==== source/reg_field_decoder.sv ====
// register field decode per lane
// picks architectural source and destination numbers by pre-decoded type
module reg_field_decoder (
  input  frontend_pkg::slot_t [frontend_pkg::DECODE_WIDTH-1:0]     slot_i,
  output frontend_pkg::dec_inst_t [frontend_pkg::DECODE_WIDTH-1:0] dec_o
);
  import frontend_pkg::*;

  function automatic logic [AREG_W-1:0] src_field(src_type_e t, logic [XLEN-1:0] instr);
    case (t)
      SRC_RD:  src_field = instr[4:0];
      SRC_RJ:  src_field = instr[9:5];
      SRC_RK:  src_field = instr[14:10];
      default: src_field = '0;
    endcase
  endfunction

  function automatic logic [AREG_W-1:0] dest_field(dest_type_e t, logic [XLEN-1:0] instr);
    case (t)
      DEST_RD: dest_field = instr[4:0];
      // rd/rj merge
      DEST_JD: dest_field = instr[9:5] | instr[4:0];
      // link register
      DEST_RA: dest_field = AREG_W'(1);
      default: dest_field = '0;
    endcase
  endfunction

  always_comb begin
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      dec_o[k].pc    = slot_i[k].pc;
      dec_o[k].instr = slot_i[k].instr;
      dec_o[k].src0  = src_field(slot_i[k].src0_type, slot_i[k].instr);
      dec_o[k].src1  = src_field(slot_i[k].src1_type, slot_i[k].instr);
      dec_o[k].dest  = dest_field(slot_i[k].dest_type, slot_i[k].instr);
    end
  end

endmodule
